// File: src/hazardPkg.sv
package hazardPkg;

    // instruction and field types
    typedef logic [15:0] instr_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [2:0]  regIdx_t;
    typedef logic [1:0]  wbSel_t;

    // forwarding word {storeSel, enable, memToEx, source}
    typedef logic [4:0]  fwdCtrl_t;

    // writeback data sources
    localparam wbSel_t wbPc  = 2'b00;
    localparam wbSel_t wbMem = 2'b01;
    localparam wbSel_t wbAlu = 2'b10;
    localparam wbSel_t wbImm = 2'b11;

    // bit positions inside fwdCtrl_t
    localparam int FWD_STORE_SEL = 4;
    localparam int FWD_ENABLE    = 3;
    localparam int FWD_MEM_TO_EX = 2;

    // instruction field positions
    localparam int OPCODE_LSB = 11;
    localparam int RS_LSB     = 8;
    localparam int RT_LSB     = 5;

    // slots of the pending-write bus, youngest first
    localparam int STAGE_D = 0;
    localparam int STAGE_X = 1;
    localparam int STAGE_M = 2;

    // opcodes the hazard logic cares about by name
    localparam opcode_t OP_ST    = 5'b10000;
    localparam opcode_t OP_STU   = 5'b10011;
    localparam opcode_t OP_ARITH = 5'b11011;
    localparam opcode_t OP_BIT   = 5'b11010;
    localparam opcode_t OP_LBI   = 5'b11000;
    localparam opcode_t OP_HALT  = 5'b00000;
    localparam opcode_t OP_NOP   = 5'b00001;
    localparam opcode_t OP_SIIC  = 5'b00010;
    localparam opcode_t OP_RTI   = 5'b00011;

    // bubble inserted into decode
    localparam instr_t NOP_INSTR = {OP_NOP, 11'b0};

endpackage

// File: src/writerBus.sv
`timescale 1ns/1ps

// pending register writes of the stages after fetch
interface writerBus #(
    parameter int StageCount = 3
);

    // one slot per compared stage, indexed by hazardPkg::STAGE_*
    logic [StageCount-1:0]              regWrt;
    hazardPkg::regIdx_t [StageCount-1:0] wrtReg;

    // writeback source is only known for decode and execute
    hazardPkg::wbSel_t [1:0]            wbDataSel;

    modport producer (
        output regWrt,
        output wrtReg,
        output wbDataSel
    );

    modport consumer (
        input regWrt,
        input wrtReg,
        input wbDataSel
    );

endinterface

// File: src/operandDecode.sv
`timescale 1ns/1ps

module operandDecode (
    input  hazardPkg::opcode_t opcode,
    output logic               useRs,
    output logic               useRt,
    output logic               storeOp,
    output logic               exempt
);

    // which source fields the opcode actually reads
    always_comb begin
        useRs = 1'b0;
        useRt = 1'b0;
        casez (opcode)
            // rs plus rt (rt holds the store data for ST/STU)
            hazardPkg::OP_ST,
            hazardPkg::OP_STU,
            hazardPkg::OP_ARITH,
            hazardPkg::OP_BIT,
            5'b111??: begin
                useRs = 1'b1;
                useRt = 1'b1;
            end

            // branches read rs
            5'b011??: begin
                useRs = 1'b1;
            end

            // JR and JALR read rs
            5'b001?1: begin
                useRs = 1'b1;
            end

            // nothing read from the register file
            hazardPkg::OP_LBI,
            hazardPkg::OP_HALT,
            hazardPkg::OP_NOP,
            hazardPkg::OP_SIIC,
            hazardPkg::OP_RTI,
            5'b001?0: begin
                useRs = 1'b0;
                useRt = 1'b0;
            end

            // everything else is an rs-only immediate form
            default: begin
                useRs = 1'b1;
            end
        endcase
    end

    assign storeOp = (opcode == hazardPkg::OP_ST) || (opcode == hazardPkg::OP_STU);

    // siic and rti always issue, even under jumps or reset
    assign exempt = (opcode == hazardPkg::OP_SIIC) || (opcode == hazardPkg::OP_RTI);

endmodule

// File: src/operandHazard.sv
`timescale 1ns/1ps

module operandHazard (
    input  logic                  clk,
    input  hazardPkg::regIdx_t    src,
    input  logic                  used,
    input  logic                  storeOp,
    writerBus.consumer            writers,
    output logic                  stall,
    output hazardPkg::fwdCtrl_t   fwd
);

    logic            matchD;
    logic            matchX;
    logic            matchM;
    logic            loadUse;
    hazardPkg::wbSel_t fwdSrc;

    // a stage matches when it writes the register this source reads
    assign matchD = writers.regWrt[hazardPkg::STAGE_D]
                 && (writers.wrtReg[hazardPkg::STAGE_D] == src);
    assign matchX = writers.regWrt[hazardPkg::STAGE_X]
                 && (writers.wrtReg[hazardPkg::STAGE_X] == src);
    assign matchM = writers.regWrt[hazardPkg::STAGE_M]
                 && (writers.wrtReg[hazardPkg::STAGE_M] == src);

    // load in decode cannot be forwarded in time
    assign loadUse = matchD
                  && (writers.wbDataSel[hazardPkg::STAGE_D] == hazardPkg::wbMem);

    // memory-stage write has no forward path, unless a newer write shadows it
    assign stall = used && ((matchM && !matchX && !matchD) || loadUse);

    // the youngest matching stage supplies the data
    assign fwdSrc = matchD ? writers.wbDataSel[hazardPkg::STAGE_D]
                           : writers.wbDataSel[hazardPkg::STAGE_X];

    always_comb begin
        fwd = '0;
        if (used) begin
            fwd[hazardPkg::FWD_STORE_SEL] = storeOp;
            fwd[hazardPkg::FWD_ENABLE]    = (matchD || matchX) && !loadUse;
            // low selects execute-to-execute
            fwd[hazardPkg::FWD_MEM_TO_EX] = !matchD;
            fwd[1:0]                      = fwdSrc;
        end
    end

    // a source is either stalled or forwarded, never both
    stallExcludesForward: assert property (
        @(posedge clk) !(stall && fwd[hazardPkg::FWD_ENABLE])
    ) else $error("operandHazard: stall and forward enable both set");

    // unread sources must not steer the execute muxes
    unusedIsQuiet: assert property (
        @(posedge clk) !used |-> (fwd == '0) && !stall
    ) else $error("operandHazard: unused source has nonzero control");

endmodule

// File: src/issueGate.sv
`timescale 1ns/1ps

module issueGate (
    input  logic                clk,
    input  logic                reset,
    input  hazardPkg::instr_t   fetchInst,
    input  logic                exempt,
    input  logic                stallA,
    input  logic                stallB,
    input  logic                jumpInstD,
    input  logic                jumpInstX,
    output hazardPkg::instr_t   nextInst,
    output logic                pcNop
);

    logic squash;

    // any source stall holds the program counter
    assign pcNop = stallA || stallB;

    // jumps only flush the slot because the pc is redirected elsewhere
    assign squash = !exempt && (reset || pcNop || jumpInstD || jumpInstX);

    assign nextInst = squash ? hazardPkg::NOP_INSTR : fetchInst;

    // a held pc must never let the stalled instruction through
    holdInsertsBubble: assert property (
        @(posedge clk) pcNop |-> (nextInst == hazardPkg::NOP_INSTR)
    ) else $error("issueGate: pcNop raised but instruction issued");

endmodule

// File: src/hazardDet.sv
`timescale 1ns/1ps

module hazardDet #(
    parameter int StageCount = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  hazardPkg::instr_t     fetchInst,
    input  logic                  jumpInstD,
    input  logic                  jumpInstX,
    input  logic                  regWrtD,
    input  logic                  regWrtX,
    input  logic                  regWrtM,
    input  hazardPkg::regIdx_t    wrtRegD,
    input  hazardPkg::regIdx_t    wrtRegX,
    input  hazardPkg::regIdx_t    wrtRegM,
    input  hazardPkg::wbSel_t     wbDataSelD,
    input  hazardPkg::wbSel_t     wbDataSelX,
    output hazardPkg::instr_t     nextInst,
    output logic                  pcNop,
    output hazardPkg::fwdCtrl_t   fwdA,
    output hazardPkg::fwdCtrl_t   fwdB
);

    logic useRs;
    logic useRt;
    logic storeOp;
    logic exempt;
    logic stallA;
    logic stallB;

    writerBus #(.StageCount(StageCount)) writers ();

    // gather the later-stage writes onto the bus
    always_comb begin
        writers.regWrt                       = '0;
        writers.wrtReg                       = '0;
        writers.regWrt[hazardPkg::STAGE_D]   = regWrtD;
        writers.regWrt[hazardPkg::STAGE_X]   = regWrtX;
        writers.regWrt[hazardPkg::STAGE_M]   = regWrtM;
        writers.wrtReg[hazardPkg::STAGE_D]   = wrtRegD;
        writers.wrtReg[hazardPkg::STAGE_X]   = wrtRegX;
        writers.wrtReg[hazardPkg::STAGE_M]   = wrtRegM;
        writers.wbDataSel[hazardPkg::STAGE_D] = wbDataSelD;
        writers.wbDataSel[hazardPkg::STAGE_X] = wbDataSelX;
    end

    operandDecode decode (
        .opcode  (fetchInst[hazardPkg::OPCODE_LSB +: $bits(hazardPkg::opcode_t)]),
        .useRs   (useRs),
        .useRt   (useRt),
        .storeOp (storeOp),
        .exempt  (exempt)
    );

    // source A reads rs, never a store operand
    operandHazard srcA (
        .clk     (clk),
        .src     (fetchInst[hazardPkg::RS_LSB +: $bits(hazardPkg::regIdx_t)]),
        .used    (useRs),
        .storeOp (1'b0),
        .writers (writers.consumer),
        .stall   (stallA),
        .fwd     (fwdA)
    );

    // source B reads rt, which is the store data on ST/STU
    operandHazard srcB (
        .clk     (clk),
        .src     (fetchInst[hazardPkg::RT_LSB +: $bits(hazardPkg::regIdx_t)]),
        .used    (useRt),
        .storeOp (storeOp),
        .writers (writers.consumer),
        .stall   (stallB),
        .fwd     (fwdB)
    );

    issueGate gate (
        .clk       (clk),
        .reset     (reset),
        .fetchInst (fetchInst),
        .exempt    (exempt),
        .stallA    (stallA),
        .stallB    (stallB),
        .jumpInstD (jumpInstD),
        .jumpInstX (jumpInstX),
        .nextInst  (nextInst),
        .pcNop     (pcNop)
    );

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ps

// free-running clock plus a reset held for the first few cycles
module clockGen #(
    parameter int PeriodNs    = 4,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // release on a falling edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: bench/hazardDetTb.sv
`timescale 1ns/1ps

module hazardDetTb;

    localparam int PeriodNs      = 4;
    localparam int ResetCycles   = 5;
    localparam int DirectedCount = 24;
    localparam int SweepPerOp    = 4;
    localparam int RandCount     = 400;
    // margin covers reset release and the last check
    localparam int TimeoutCycles = ResetCycles + DirectedCount + 32 * SweepPerOp
                                 + RandCount + 20;
    localparam logic [5:0] idle  = 6'b0;

    logic clk;
    logic reset;
    hazardPkg::instr_t   fetchInst;
    logic                jumpInstD;
    logic                jumpInstX;
    logic                regWrtD;
    logic                regWrtX;
    logic                regWrtM;
    hazardPkg::regIdx_t  wrtRegD;
    hazardPkg::regIdx_t  wrtRegX;
    hazardPkg::regIdx_t  wrtRegM;
    hazardPkg::wbSel_t   wbDataSelD;
    hazardPkg::wbSel_t   wbDataSelX;
    hazardPkg::instr_t   nextInst;
    logic                pcNop;
    hazardPkg::fwdCtrl_t fwdA;
    hazardPkg::fwdCtrl_t fwdB;
    logic [31:0]         lfsr;

    // fields of the word currently in fetch
    hazardPkg::opcode_t  opc;
    hazardPkg::regIdx_t  rs;
    hazardPkg::regIdx_t  rt;
    logic [1:0]          srcUse;
    logic                storeOpc;

    clockGen #(.PeriodNs(PeriodNs), .ResetCycles(ResetCycles)) clocks (
        .clk   (clk),
        .reset (reset)
    );

    hazardDet #(.StageCount(3)) i_hazardDet (
        .clk        (clk),
        .reset      (reset),
        .fetchInst  (fetchInst),
        .jumpInstD  (jumpInstD),
        .jumpInstX  (jumpInstX),
        .regWrtD    (regWrtD),
        .regWrtX    (regWrtX),
        .regWrtM    (regWrtM),
        .wrtRegD    (wrtRegD),
        .wrtRegX    (wrtRegX),
        .wrtRegM    (wrtRegM),
        .wbDataSelD (wbDataSelD),
        .wbDataSelX (wbDataSelX),
        .nextInst   (nextInst),
        .pcNop      (pcNop),
        .fwdA       (fwdA),
        .fwdB       (fwdB)
    );

    // {reads rs, reads rt} by opcode class
    function automatic logic [1:0] sourcesRead(hazardPkg::opcode_t op);
        logic none;
        logic both;
        none = (op == hazardPkg::OP_LBI) || (op == hazardPkg::OP_HALT)
            || (op == hazardPkg::OP_NOP) || (op == hazardPkg::OP_SIIC)
            || (op == hazardPkg::OP_RTI) || ((op[4:2] == 3'b001) && !op[0]);
        both = (op == hazardPkg::OP_ST) || (op == hazardPkg::OP_STU)
            || (op == hazardPkg::OP_ARITH) || (op == hazardPkg::OP_BIT)
            || (op[4:2] == 3'b111);
        return {!none, both};
    endfunction

    assign opc      = fetchInst[hazardPkg::OPCODE_LSB +: 5];
    assign rs       = fetchInst[hazardPkg::RS_LSB +: 3];
    assign rt       = fetchInst[hazardPkg::RT_LSB +: 3];
    assign srcUse   = sourcesRead(opc);
    assign storeOpc = (opc == hazardPkg::OP_ST) || (opc == hazardPkg::OP_STU);

    function automatic logic hits(logic wr, hazardPkg::regIdx_t dst, hazardPkg::regIdx_t src);
        return wr && (dst == src);
    endfunction

    function automatic logic stallRule(hazardPkg::regIdx_t src, logic used);
        logic mD;
        logic mX;
        logic mM;
        mD = hits(regWrtD, wrtRegD, src);
        mX = hits(regWrtX, wrtRegX, src);
        mM = hits(regWrtM, wrtRegM, src);
        return used && ((mM && !mX && !mD) || (mD && (wbDataSelD == hazardPkg::wbMem)));
    endfunction

    function automatic hazardPkg::fwdCtrl_t fwdRule(hazardPkg::regIdx_t src, logic used,
                                                    logic isStore);
        logic mD;
        logic mX;
        logic loadUse;
        mD = hits(regWrtD, wrtRegD, src);
        mX = hits(regWrtX, wrtRegX, src);
        loadUse = mD && (wbDataSelD == hazardPkg::wbMem);
        if (!used)
            return '0;
        return {isStore, (mD || mX) && !loadUse, !mD, mD ? wbDataSelD : wbDataSelX};
    endfunction

    function automatic logic pcNopRule();
        return stallRule(rs, srcUse[1]) || stallRule(rt, srcUse[0]);
    endfunction

    function automatic hazardPkg::instr_t issueRule();
        logic exempt;
        exempt = (opc == hazardPkg::OP_SIIC) || (opc == hazardPkg::OP_RTI);
        if (!exempt && (reset || pcNopRule() || jumpInstD || jumpInstX))
            return hazardPkg::NOP_INSTR;
        return fetchInst;
    endfunction

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "run stopped at first error");
    endtask

    fwdAOk: assert property (@(posedge clk) fwdA == fwdRule(rs, srcUse[1], 1'b0))
        else failRun($sformatf("MISMATCH at %0t: fwdA is %h, expected %h",
                               $time, fwdA, fwdRule(rs, srcUse[1], 1'b0)));
    fwdBOk: assert property (@(posedge clk) fwdB == fwdRule(rt, srcUse[0], storeOpc))
        else failRun($sformatf("MISMATCH at %0t: fwdB is %h, expected %h",
                               $time, fwdB, fwdRule(rt, srcUse[0], storeOpc)));
    pcNopOk: assert property (@(posedge clk) pcNop == pcNopRule())
        else failRun($sformatf("MISMATCH at %0t: pcNop is %b, expected %b",
                               $time, pcNop, pcNopRule()));
    nextInstOk: assert property (@(posedge clk) nextInst == issueRule())
        else failRun($sformatf("MISMATCH at %0t: nextInst is %h, expected %h",
                               $time, nextInst, issueRule()));

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] takeBits(int count);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [5:0] pending(logic wr, hazardPkg::regIdx_t dst,
                                           hazardPkg::wbSel_t sel);
        return {wr, dst, sel};
    endfunction

    function automatic hazardPkg::instr_t instrOf(hazardPkg::opcode_t op,
                                                  hazardPkg::regIdx_t a, hazardPkg::regIdx_t b);
        return {op, a, b, 5'b0};
    endfunction

    // writers packed as {D, X, M}, the M select bits are unused
    task automatic apply(hazardPkg::instr_t inst, logic [1:0] jumps, logic [17:0] wr);
        @(negedge clk);
        fetchInst = inst;
        {jumpInstD, jumpInstX} = jumps;
        {regWrtD, wrtRegD, wbDataSelD} = wr[17:12];
        {regWrtX, wrtRegX, wbDataSelX} = wr[11:6];
        {regWrtM, wrtRegM} = wr[5:2];
    endtask

    // registers kept in 0..3 so that matches are frequent
    task automatic randomVec(hazardPkg::opcode_t op);
        logic [31:0] r;
        logic [17:0] wr;
        logic [1:0]  jumps;
        r = takeBits(9);
        jumps[1] = (takeBits(3) == 32'd0);
        jumps[0] = (takeBits(3) == 32'd0);
        for (int s = 0; s < 3; s++) begin
            wr[17 - 6 * s -: 6] = {takeBits(1) == 32'd1, 1'b0, takeBits(4) == 32'd0 ? 2'b00 : r[1:0],
                                   2'b00};
            wr[17 - 6 * s - 4 -: 2] = takeBits(2) == 32'd0 ? 2'b00 : r[5:4];
        end
        apply({op, 1'b0, r[1:0], 1'b0, r[3:2], r[8:4]}, jumps, wr);
    endtask

    initial begin
        logic [31:0] draw;
        lfsr = 32'hde5a1c5b;
        fetchInst = hazardPkg::NOP_INSTR;
        {jumpInstD, jumpInstX, regWrtD, regWrtX, regWrtM} = '0;
        {wrtRegD, wrtRegX, wrtRegM, wbDataSelD, wbDataSelX} = '0;
        // under reset: bubble except for siic, pcNop still from stalls
        apply(instrOf(hazardPkg::OP_ARITH, 3'd1, 3'd2), 2'b00, {idle, idle, idle});
        apply(instrOf(hazardPkg::OP_SIIC, 3'd1, 3'd2), 2'b00, {idle, idle, idle});
        apply(instrOf(hazardPkg::OP_ARITH, 3'd3, 3'd4), 2'b00,
              {pending(1'b1, 3'd3, hazardPkg::wbMem), idle, idle});
        wait (!reset);
        // load-use on rs, then on rt
        apply(instrOf(hazardPkg::OP_ARITH, 3'd3, 3'd4), 2'b00,
              {pending(1'b1, 3'd3, hazardPkg::wbMem), idle, idle});
        apply(instrOf(hazardPkg::OP_BIT, 3'd1, 3'd5), 2'b00,
              {pending(1'b1, 3'd5, hazardPkg::wbMem), idle, idle});
        // forwarding from D, then from X only
        apply(instrOf(hazardPkg::OP_ARITH, 3'd2, 3'd6), 2'b00,
              {pending(1'b1, 3'd2, hazardPkg::wbAlu), idle, idle});
        apply(instrOf(hazardPkg::OP_ARITH, 3'd2, 3'd6), 2'b00,
              {pending(1'b1, 3'd6, hazardPkg::wbImm), idle, idle});
        apply(instrOf(hazardPkg::OP_ARITH, 3'd7, 3'd1), 2'b00,
              {pending(1'b1, 3'd3, hazardPkg::wbAlu), pending(1'b1, 3'd7, hazardPkg::wbPc), idle});
        // M-only stall, then cancelled by a newer X or D write
        apply(instrOf(hazardPkg::OP_ARITH, 3'd4, 3'd0), 2'b00,
              {idle, idle, pending(1'b1, 3'd4, hazardPkg::wbPc)});
        apply(instrOf(hazardPkg::OP_ARITH, 3'd4, 3'd0), 2'b00,
              {idle, pending(1'b1, 3'd4, hazardPkg::wbAlu), pending(1'b1, 3'd4, hazardPkg::wbPc)});
        apply(instrOf(hazardPkg::OP_ARITH, 3'd4, 3'd0), 2'b00,
              {pending(1'b1, 3'd4, hazardPkg::wbImm), idle, pending(1'b1, 3'd4, hazardPkg::wbPc)});
        apply(instrOf(5'b11100, 3'd1, 3'd4), 2'b00,
              {idle, idle, pending(1'b1, 3'd4, hazardPkg::wbPc)});
        // jumps squash ordinary words, siic and rti still pass
        apply(instrOf(hazardPkg::OP_ARITH, 3'd1, 3'd2), 2'b10, {idle, idle, idle});
        apply(instrOf(hazardPkg::OP_ARITH, 3'd1, 3'd2), 2'b01, {idle, idle, idle});
        apply(instrOf(hazardPkg::OP_SIIC, 3'd1, 3'd2), 2'b10, {idle, idle, idle});
        apply(instrOf(hazardPkg::OP_RTI, 3'd5, 3'd5), 2'b01,
              {idle, idle, pending(1'b1, 3'd5, hazardPkg::wbPc)});
        // stores carry storeSel on B
        apply(instrOf(hazardPkg::OP_ST, 3'd1, 3'd2), 2'b00,
              {idle, pending(1'b1, 3'd2, hazardPkg::wbAlu), idle});
        apply(instrOf(hazardPkg::OP_STU, 3'd2, 3'd3), 2'b00,
              {pending(1'b1, 3'd3, hazardPkg::wbImm), idle, idle});
        apply(instrOf(hazardPkg::OP_ST, 3'd1, 3'd2), 2'b00,
              {pending(1'b1, 3'd2, hazardPkg::wbMem), idle, idle});
        // rs-only and no-source classes
        apply(instrOf(5'b01000, 3'd1, 3'd2), 2'b00,
              {pending(1'b1, 3'd2, hazardPkg::wbAlu), pending(1'b1, 3'd1, hazardPkg::wbAlu), idle});
        apply(instrOf(5'b01100, 3'd5, 3'd6), 2'b00,
              {idle, idle, pending(1'b1, 3'd5, hazardPkg::wbPc)});
        apply(instrOf(5'b00101, 3'd6, 3'd6), 2'b00,
              {pending(1'b1, 3'd6, hazardPkg::wbAlu), idle, idle});
        apply(instrOf(hazardPkg::OP_LBI, 3'd1, 3'd1), 2'b00,
              {pending(1'b1, 3'd1, hazardPkg::wbMem), pending(1'b1, 3'd1, hazardPkg::wbAlu),
               pending(1'b1, 3'd1, hazardPkg::wbPc)});
        apply(instrOf(5'b00100, 3'd1, 3'd1), 2'b00,
              {idle, idle, pending(1'b1, 3'd1, hazardPkg::wbPc)});
        for (int op = 0; op < 32; op++) begin
            repeat (SweepPerOp) randomVec(op[4:0]);
        end
        repeat (RandCount) begin
            draw = takeBits(5);
            randomVec(draw[4:0]);
        end
        // one more rising edge so the last word is checked
        @(posedge clk);
        @(negedge clk);
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(TimeoutCycles * PeriodNs);
        failRun("timeout: stimulus did not finish in the expected time");
    end

endmodule

// File: list.f
src/hazardPkg.sv
src/writerBus.sv
src/operandDecode.sv
src/operandHazard.sv
src/issueGate.sv
src/hazardDet.sv
bench/clockGen.sv
bench/hazardDetTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= hazardDetTb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f list.f

clean:
	rm -rf $(BUILD_DIR) $(LOG)
